/* include/ray_box_consts.svh */
`ifndef RAY_BOX_CONSTS_SVH
`define RAY_BOX_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// fixed-point formats
////////////////////////////////////////////////////////////////////////////

// origin and box corners, signed Q8.8
`define COORD_W 16

// fraction bits in a coordinate and in a reciprocal
`define FRAC_W 8

// reciprocal direction, signed Q8.8
`define RECIP_W 16

////////////////////////////////////////////////////////////////////////////
// pipeline latencies in cycles
////////////////////////////////////////////////////////////////////////////

`define AXIS_LAT 3 // subtract, multiply, order
`define MERGE_LAT 2 // max/min, decide

`endif

/* rtl/ray_box_pkg.sv */
`include "ray_box_consts.svh"

package ray_box_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////////////////////

	localparam int DIFF_W = `COORD_W + 1; // face minus origin never overflows
	localparam int TVAL_W = DIFF_W + `RECIP_W; // full product, Q17.16

	////////////////////////////////////////////////////////////////////////////
	// types
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [`COORD_W-1:0] coord_t; // Q8.8
	typedef logic signed [`RECIP_W-1:0] recip_t; // Q8.8
	typedef logic signed [DIFF_W-1:0] diff_t; // Q9.8
	typedef logic signed [TVAL_W-1:0] tval_t; // Q17.16

	// unbounded interval ends, used by a parallel axis
	localparam tval_t T_NEG_INF = {1'b1, {(TVAL_W-1){1'b0}}};
	localparam tval_t T_POS_INF = {1'b0, {(TVAL_W-1){1'b1}}};

endpackage

/* rtl/delay_line.sv */
module delay_line #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input logic clk,
	input logic rst,
	input T d,
	output T q
);

	T stage [DEPTH]; // stage[0] is the first register

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				stage[i] <= '0;
			end
		end else begin
			stage[0] <= d;
			for (int i = 1; i < DEPTH; i++) begin
				stage[i] <= stage[i-1]; // shift along the chain
			end
		end
	end

	assign q = stage[DEPTH-1];

endmodule

/* rtl/slab_axis.sv */
module slab_axis (
	input logic clk,
	input logic rst,
	input ray_box_pkg::coord_t org,
	input ray_box_pkg::coord_t lo,
	input ray_box_pkg::coord_t hi,
	input ray_box_pkg::recip_t inv,
	input logic par,
	output ray_box_pkg::tval_t t_enter,
	output ray_box_pkg::tval_t t_exit,
	output logic axis_miss
);

	import ray_box_pkg::*;

	// stage 1
	diff_t diff_lo_s1; // lo - org
	diff_t diff_hi_s1; // hi - org
	recip_t inv_s1;
	logic outside; // org not within [lo, hi]

	// stage 2
	tval_t prod_lo_s2;
	tval_t prod_hi_s2;
	logic inv_neg_s2; // ray runs towards -axis
	logic [1:0] flags_s2; // {par, outside}

	////////////////////////////////////////////////////////////////////////////
	// stage 1: face offsets and origin range check
	////////////////////////////////////////////////////////////////////////////

	assign outside = (org < lo) || (org > hi);

	always_ff @(posedge clk) begin
		diff_lo_s1 <= diff_t'(lo) - diff_t'(org); // exact in 17 bits
		diff_hi_s1 <= diff_t'(hi) - diff_t'(org);
	end

	delay_line #(
		.T(recip_t),
		.DEPTH(1)
	) u_inv_dly (
		.clk(clk),
		.rst(rst),
		.d(inv),
		.q(inv_s1)
	);

	// flags ride along until the ordering stage
	delay_line #(
		.T(logic [1:0]),
		.DEPTH(2)
	) u_flag_dly (
		.clk(clk),
		.rst(rst),
		.d({par, outside}),
		.q(flags_s2)
	);

	////////////////////////////////////////////////////////////////////////////
	// stage 2: scale by reciprocal direction
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		prod_lo_s2 <= tval_t'(diff_lo_s1) * tval_t'(inv_s1); // Q17.16, no rounding
		prod_hi_s2 <= tval_t'(diff_hi_s1) * tval_t'(inv_s1);
		inv_neg_s2 <= inv_s1[$bits(recip_t)-1];
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 3: order into entry and exit
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (flags_s2[1]) begin
			// parallel axis never limits the interval, it can only reject
			t_enter <= T_NEG_INF;
			t_exit <= T_POS_INF;
			axis_miss <= flags_s2[0];
		end else if (inv_neg_s2) begin
			t_enter <= prod_hi_s2; // hi face is met first
			t_exit <= prod_lo_s2;
			axis_miss <= 1'b0;
		end else begin
			t_enter <= prod_lo_s2;
			t_exit <= prod_hi_s2;
			axis_miss <= 1'b0;
		end
	end

endmodule

/* rtl/interval_merge.sv */
module interval_merge (
	input logic clk,
	input logic rst,
	input logic slab_valid,
	input ray_box_pkg::tval_t enter_x,
	input ray_box_pkg::tval_t enter_y,
	input ray_box_pkg::tval_t enter_z,
	input ray_box_pkg::tval_t exit_x,
	input ray_box_pkg::tval_t exit_y,
	input ray_box_pkg::tval_t exit_z,
	input logic miss_x,
	input logic miss_y,
	input logic miss_z,
	output logic hit_valid,
	output logic hit,
	output ray_box_pkg::tval_t t_near,
	output ray_box_pkg::tval_t t_far
);

	import ray_box_pkg::*;

	tval_t near_s1; // largest entry
	tval_t far_s1; // smallest exit
	logic miss_s1;
	logic valid_s1;

	function automatic tval_t max3(input tval_t a, input tval_t b, input tval_t c);
		tval_t m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	function automatic tval_t min3(input tval_t a, input tval_t b, input tval_t c);
		tval_t m;
		m = (a < b) ? a : b;
		return (m < c) ? m : c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stage 1: intersect the three slabs
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		near_s1 <= max3(enter_x, enter_y, enter_z);
		far_s1 <= min3(exit_x, exit_y, exit_z);
		miss_s1 <= miss_x | miss_y | miss_z; // any parallel axis outside
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_s1 <= 1'b0;
			hit_valid <= 1'b0;
		end else begin
			valid_s1 <= slab_valid;
			hit_valid <= valid_s1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage 2: hit decision
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// box must be in front of the origin, not only overlapping
		hit <= !miss_s1 && (near_s1 <= far_s1) && (far_s1 > 0);
		t_near <= near_s1;
		t_far <= far_s1;
	end

endmodule

/* rtl/ray_box_top.sv */
`include "ray_box_consts.svh"

module ray_box_top (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input ray_box_pkg::coord_t org_x,
	input ray_box_pkg::coord_t org_y,
	input ray_box_pkg::coord_t org_z,
	input ray_box_pkg::coord_t lo_x,
	input ray_box_pkg::coord_t lo_y,
	input ray_box_pkg::coord_t lo_z,
	input ray_box_pkg::coord_t hi_x,
	input ray_box_pkg::coord_t hi_y,
	input ray_box_pkg::coord_t hi_z,
	input ray_box_pkg::recip_t inv_x,
	input ray_box_pkg::recip_t inv_y,
	input ray_box_pkg::recip_t inv_z,
	input logic par_x,
	input logic par_y,
	input logic par_z,
	output logic hit_valid,
	output logic hit,
	output ray_box_pkg::tval_t t_near,
	output ray_box_pkg::tval_t t_far
);

	import ray_box_pkg::*;

	tval_t enter_x, enter_y, enter_z;
	tval_t exit_x, exit_y, exit_z;
	logic miss_x, miss_y, miss_z;
	logic slab_valid; // in_valid aligned with the slab outputs

	////////////////////////////////////////////////////////////////////////////
	// per-axis slabs
	////////////////////////////////////////////////////////////////////////////

	slab_axis u_slab_x (
		.clk(clk), .rst(rst),
		.org(org_x), .lo(lo_x), .hi(hi_x), .inv(inv_x), .par(par_x),
		.t_enter(enter_x), .t_exit(exit_x), .axis_miss(miss_x)
	);

	slab_axis u_slab_y (
		.clk(clk), .rst(rst),
		.org(org_y), .lo(lo_y), .hi(hi_y), .inv(inv_y), .par(par_y),
		.t_enter(enter_y), .t_exit(exit_y), .axis_miss(miss_y)
	);

	slab_axis u_slab_z (
		.clk(clk), .rst(rst),
		.org(org_z), .lo(lo_z), .hi(hi_z), .inv(inv_z), .par(par_z),
		.t_enter(enter_z), .t_exit(exit_z), .axis_miss(miss_z)
	);

	delay_line #(
		.T(logic),
		.DEPTH(`AXIS_LAT)
	) u_valid_dly (
		.clk(clk),
		.rst(rst),
		.d(in_valid),
		.q(slab_valid)
	);

	////////////////////////////////////////////////////////////////////////////
	// merge and decide
	////////////////////////////////////////////////////////////////////////////

	interval_merge u_merge (
		.clk(clk), .rst(rst),
		.slab_valid(slab_valid),
		.enter_x(enter_x), .enter_y(enter_y), .enter_z(enter_z),
		.exit_x(exit_x), .exit_y(exit_y), .exit_z(exit_z),
		.miss_x(miss_x), .miss_y(miss_y), .miss_z(miss_z),
		.hit_valid(hit_valid), .hit(hit),
		.t_near(t_near), .t_far(t_far)
	);

endmodule

/* dv/ray_box_checker.sv */
`include "ray_box_consts.svh"

module ray_box_checker (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic hit_valid,
	input logic hit,
	input ray_box_pkg::tval_t t_near,
	input ray_box_pkg::tval_t t_far
);

	import ray_box_pkg::*;

	localparam int LATENCY = `AXIS_LAT + `MERGE_LAT; // strobe to result

	////////////////////////////////////////////////////////////////////////////
	// protocol properties
	////////////////////////////////////////////////////////////////////////////

	a_quiet_in_reset: assert property (@(posedge clk) rst |-> !hit_valid)
		else $error("hit_valid high while rst is asserted");

	a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
		hit_valid == $past(in_valid, LATENCY))
		else $error("hit_valid does not follow in_valid by the pipeline latency");

	// a reported hit must carry a non-empty interval
	a_ordered_interval: assert property (@(posedge clk) disable iff (rst)
		(hit_valid && hit) |-> (t_near <= t_far))
		else $error("hit reported with t_near above t_far");

endmodule

bind ray_box_top ray_box_checker u_checker (
	.clk(clk),
	.rst(rst),
	.in_valid(in_valid),
	.hit_valid(hit_valid),
	.hit(hit),
	.t_near(t_near),
	.t_far(t_far)
);

/* dv/ray_box_tb.sv */
`include "ray_box_consts.svh"

module ray_box_tb;

	import ray_box_pkg::*;

	localparam int NUM_RAYS = 2000;
	localparam int SEED = 75;
	localparam int LATENCY = `AXIS_LAT + `MERGE_LAT;
	localparam int DRAIN_TIMEOUT = 100; // cycles to wait for the last results
	localparam int IDLE_TAIL = 20; // quiet cycles checked after the drain

	logic clk;
	logic rst;
	logic in_valid;
	coord_t org_x, org_y, org_z;
	coord_t lo_x, lo_y, lo_z;
	coord_t hi_x, hi_y, hi_z;
	recip_t inv_x, inv_y, inv_z;
	logic par_x, par_y, par_z;
	logic hit_valid;
	logic hit;
	tval_t t_near;
	tval_t t_far;

	// current ray indexed by axis 0..2 for x, y, z
	coord_t org [3];
	coord_t lo [3];
	coord_t hi [3];
	recip_t inv [3];
	logic par [3];

	// expected results in issue order
	logic exp_hit [$];
	tval_t exp_near [$];
	tval_t exp_far [$];
	int exp_cycle [$];

	int unsigned rng_state = SEED;
	int cycle_count = 0;
	int hit_count = 0;
	int par_in_count = 0;
	int par_out_count = 0;

	ray_box_top uut (
		.clk(clk), .rst(rst), .in_valid(in_valid),
		.org_x(org_x), .org_y(org_y), .org_z(org_z),
		.lo_x(lo_x), .lo_y(lo_y), .lo_z(lo_z),
		.hi_x(hi_x), .hi_y(hi_y), .hi_z(hi_z),
		.inv_x(inv_x), .inv_y(inv_y), .inv_z(inv_z),
		.par_x(par_x), .par_y(par_y), .par_z(par_z),
		.hit_valid(hit_valid), .hit(hit), .t_near(t_near), .t_far(t_far)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 8; // low lcg bits are weak
	endfunction

	function automatic int rand_below(input int unsigned n);
		return int'(next_rand() % n);
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic check_hit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0t: %s is %0b, expected %0b",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_tval(input tval_t actual, input tval_t expected, input string what);
		if (actual !== expected) begin
			stop_run($sformatf("[ERROR] %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	// random box per axis with the origin sometimes inside it
	task automatic make_ray();
		logic org_in_box;
		int span;
		org_in_box = (rand_below(4) == 0);
		for (int a = 0; a < 3; a++) begin
			lo[a] = coord_t'(rand_below(16385) - 8192); // +-32.0
			hi[a] = coord_t'(int'(lo[a]) + rand_below(4096) + 1);
			span = int'(hi[a]) - int'(lo[a]) + 1;
			if (org_in_box) begin
				org[a] = coord_t'(int'(lo[a]) + rand_below(span));
			end else begin
				org[a] = coord_t'(rand_below(20481) - 10240); // +-40.0
			end
			inv[a] = recip_t'(rand_below(2049) - 1024); // +-4.0 including zero
			par[a] = (rand_below(8) == 0);
		end
	endtask

	// slab method on exact integers with sentinels for a parallel axis
	task automatic model_ray(output logic e_hit, output tval_t e_near, output tval_t e_far);
		longint near;
		longint far;
		longint p_lo;
		longint p_hi;
		longint t_in;
		longint t_out;
		logic miss;
		near = longint'(T_NEG_INF);
		far = longint'(T_POS_INF);
		miss = 1'b0;
		for (int a = 0; a < 3; a++) begin
			if (par[a]) begin
				if (org[a] < lo[a] || org[a] > hi[a]) begin
					miss = 1'b1;
					par_out_count++;
				end else begin
					par_in_count++;
				end
				t_in = longint'(T_NEG_INF);
				t_out = longint'(T_POS_INF);
			end else begin
				p_lo = (longint'(lo[a]) - longint'(org[a])) * longint'(inv[a]);
				p_hi = (longint'(hi[a]) - longint'(org[a])) * longint'(inv[a]);
				if (inv[a] < 0) begin
					t_in = p_hi; // travelling towards -axis
					t_out = p_lo;
				end else begin
					t_in = p_lo;
					t_out = p_hi;
				end
			end
			if (t_in > near) near = t_in;
			if (t_out < far) far = t_out;
		end
		e_hit = !miss && (near <= far) && (far > 0);
		e_near = tval_t'(near);
		e_far = tval_t'(far);
		if (e_hit) hit_count++;
	endtask

	task automatic drive_inputs(input logic valid);
		in_valid = valid;
		org_x = org[0];
		org_y = org[1];
		org_z = org[2];
		lo_x = lo[0];
		lo_y = lo[1];
		lo_z = lo[2];
		hi_x = hi[0];
		hi_y = hi[1];
		hi_z = hi[2];
		inv_x = inv[0];
		inv_y = inv[1];
		inv_z = inv[2];
		par_x = par[0];
		par_y = par[1];
		par_z = par[2];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic e_hit;
		tval_t e_near;
		tval_t e_far;
		int gap;
		int waited;
		rst = 1'b1;
		for (int a = 0; a < 3; a++) begin
			org[a] = '0;
			lo[a] = '0;
			hi[a] = '0;
			inv[a] = '0;
			par[a] = 1'b0;
		end
		drive_inputs(1'b0);
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		for (int i = 0; i < NUM_RAYS; i++) begin
			gap = (rand_below(2) == 0) ? 0 : rand_below(4); // half back to back
			repeat (gap) begin
				@(posedge clk);
				#1 in_valid = 1'b0;
			end
			make_ray();
			model_ray(e_hit, e_near, e_far);
			@(posedge clk);
			#1 drive_inputs(1'b1);
			exp_hit.push_back(e_hit);
			exp_near.push_back(e_near);
			exp_far.push_back(e_far);
			exp_cycle.push_back(cycle_count + LATENCY);
		end
		@(posedge clk);
		#1 in_valid = 1'b0;
		waited = 0;
		while (exp_hit.size() != 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_hit.size() == 0) begin
			repeat (IDLE_TAIL) @(posedge clk); // nothing may appear while idle
			$display("rays %0d, hits %0d, parallel axes inside %0d, outside %0d",
				NUM_RAYS, hit_count, par_in_count, par_out_count);
			$display("test passed");
			$finish;
		end else begin
			$display("timed out waiting for %0d outstanding results", exp_hit.size());
			$display("test failed");
			$fatal(1);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// result monitor sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		logic e_hit;
		tval_t e_near;
		tval_t e_far;
		int e_cycle;
		if (hit_valid !== 1'b0 && hit_valid !== 1'b1) begin
			stop_run("hit_valid is unknown");
		end else if (hit_valid) begin
			if (exp_hit.size() == 0) begin
				stop_run("a result appeared with no ray in flight");
			end else begin
				e_hit = exp_hit.pop_front();
				e_near = exp_near.pop_front();
				e_far = exp_far.pop_front();
				e_cycle = exp_cycle.pop_front();
				if (cycle_count != e_cycle) begin
					stop_run($sformatf("[ERROR] %0t: result at cycle %0d, expected cycle %0d",
						$time, cycle_count, e_cycle));
				end
				check_hit(hit, e_hit, "hit");
				check_tval(t_near, e_near, "t_near");
				check_tval(t_far, e_far, "t_far");
			end
		end else if (exp_cycle.size() != 0 && exp_cycle[0] <= cycle_count) begin
			stop_run($sformatf("[ERROR] %0t: no result at cycle %0d, expected one",
				$time, cycle_count));
		end
	end

endmodule

/* filelist.f */
+incdir+include
rtl/ray_box_pkg.sv
rtl/delay_line.sv
rtl/slab_axis.sv
rtl/interval_merge.sv
rtl/ray_box_top.sv
dv/ray_box_checker.sv
dv/ray_box_tb.sv

/* Makefile */
# Verilator build and run for the ray/box intersection testbench

VERILATOR ?= verilator
TOP       ?= ray_box_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= test passed

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
